//--- Makefile
VERILATOR ?= verilator
TOP       := dmem_tb
FLIST     := dmem.f
OBJ_DIR   := obj_dir
VFLAGS    := --binary --assert --timing -Wno-fatal -j 0 --top-module $(TOP) --Mdir $(OBJ_DIR)
BIN       := $(OBJ_DIR)/V$(TOP)
LOG       := sim.log
SRCS      := $(filter-out +%,$(shell cat $(FLIST)))

.PHONY: all run clean

all: run

$(BIN): $(SRCS) $(FLIST)
	$(VERILATOR) $(VFLAGS) -f $(FLIST)

run: $(BIN)
	-./$(BIN) > $(LOG) 2>&1
	@cat $(LOG)
	@if grep -q "Test FAILED" $(LOG); then echo "simulation failed"; exit 1; fi
	@if ! grep -q "Test OK" $(LOG); then echo "simulation ended without a result"; exit 1; fi
	@echo "simulation passed"

clean:
	rm -rf $(OBJ_DIR) $(LOG)

//--- common/dmem_pkg.sv
// data memory shared definitions

package dmem_pkg;

  //////////////////////////////////////////////////
  // widths with a meaning
  //////////////////////////////////////////////////

  localparam int IDX_W = 16;                  // word index bits carried in a ram command.

  typedef logic [63:0] addr_t;                // byte address of a request.
  typedef logic [63:0] xdata_t;               // register-width data.
  typedef logic [7:0]  byte_mask_t;           // one enable per byte lane.
  typedef logic [2:0]  memop_t;               // memory-operation code.
  typedef logic [2:0]  lane_t;                // byte offset inside a word.
  typedef logic [7:0]  fault_cnt_t;           // saturating fault count.
  typedef logic [IDX_W-1:0] word_idx_t;       // 64-bit word index.

  // operation codes, width in bits [2:1], code 7 is illegal
  localparam memop_t MEMOP_LB  = 3'b000;      // byte, signed.
  localparam memop_t MEMOP_LBU = 3'b001;      // byte, unsigned.
  localparam memop_t MEMOP_LH  = 3'b010;      // half, signed.
  localparam memop_t MEMOP_LHU = 3'b011;      // half, unsigned.
  localparam memop_t MEMOP_LW  = 3'b100;      // word, signed.
  localparam memop_t MEMOP_LWU = 3'b101;      // word, unsigned.
  localparam memop_t MEMOP_LD  = 3'b110;      // doubleword.

  localparam fault_cnt_t FAULT_CNT_MAX = 8'hff; // count sticks here.

  //////////////////////////////////////////////////
  // block to block bundles
  //////////////////////////////////////////////////

  typedef struct packed {
    logic       en;                           // access the ram this cycle.
    logic       we;                           // write under mask.
    word_idx_t  index;                        // word index, low bits used.
    byte_mask_t mask;                         // lanes to write.
    xdata_t     wdata;                        // lane-aligned store data.
  } ram_cmd_t;

  typedef struct packed {
    logic   valid;                            // accepted load.
    memop_t memop;                            // width and sign.
    lane_t  offset;                           // first byte lane.
  } load_tag_t;

  typedef struct packed {
    logic  valid;                             // request was rejected.
    addr_t addr;                              // its address.
  } fault_evt_t;

endpackage

//--- dmem.f
common/dmem_pkg.sv
verilog/dmem_ram.sv
verilog/dmem_fault_regs.sv
lsu/lsu_access_decode.sv
lsu/lsu_load_extend.sv
verilog/dmem_top.sv
test/dmem_chk.sv
test/dmem_tb.sv

//--- lsu/lsu_access_decode.sv
// load store request decode

module lsu_access_decode
  import dmem_pkg::*;
(
  input  logic       i_req,                   // request strobe.
  input  logic       i_wr,                    // store when set.
  input  memop_t     i_memop,
  input  addr_t      i_addr,
  input  xdata_t     i_wdata,
  output ram_cmd_t   o_cmd,
  output load_tag_t  o_tag,
  output fault_evt_t o_fault
);

  byte_mask_t base_mask;                      // mask at lane zero.
  lane_t      align_bits;                     // address bits that must be zero.
  lane_t      offset;                         // byte lane of the access.
  logic       op_ok;                          // code is 0 to 6.
  logic       legal;                          // code ok and aligned.
  logic       accept;                         // request goes to the ram.

  assign offset = i_addr[2:0];

  //////////////////////////////////////////////////
  // width from the operation code
  //////////////////////////////////////////////////

  always_comb begin
    op_ok      = 1'b1;
    base_mask  = '0;
    align_bits = '0;
    case (i_memop)
      MEMOP_LB, MEMOP_LBU: begin base_mask = 8'h01; align_bits = 3'b000; end // any address.
      MEMOP_LH, MEMOP_LHU: begin base_mask = 8'h03; align_bits = 3'b001; end // even.
      MEMOP_LW, MEMOP_LWU: begin base_mask = 8'h0f; align_bits = 3'b011; end // by four.
      MEMOP_LD:            begin base_mask = 8'hff; align_bits = 3'b111; end // by eight.
      default:             op_ok = 1'b0;      // code 7, no access.
    endcase
  end

  assign legal  = op_ok && ((offset & align_bits) == '0);
  assign accept = i_req && legal;

  //////////////////////////////////////////////////
  // command, tag and fault bundles
  //////////////////////////////////////////////////

  always_comb begin
    o_cmd.en    = accept;
    o_cmd.we    = accept && i_wr;
    o_cmd.index = i_addr[IDX_W+2:3];          // word index from bit 3.
    o_cmd.mask  = (accept && i_wr) ? byte_mask_t'(base_mask << offset) : '0;
    o_cmd.wdata = i_wdata << {offset, 3'b000}; // move data into its lanes.

    o_tag.valid  = accept && !i_wr;           // only loads respond.
    o_tag.memop  = i_memop;
    o_tag.offset = offset;

    o_fault.valid = i_req && !legal;          // rejected request.
    o_fault.addr  = i_addr;
  end

endmodule

//--- lsu/lsu_load_extend.sv
// load data align and extend

module lsu_load_extend
  import dmem_pkg::*;
(
  input  logic      i_clk,
  input  logic      i_rst_n,
  input  load_tag_t i_tag,                    // tag in the request cycle.
  input  xdata_t    i_raw,                    // ram word, one cycle later.
  output logic      o_rvalid,
  output xdata_t    o_rdata
);

  logic   valid_q;                            // load in the ram stage.
  memop_t memop_q;                            // its width and sign.
  lane_t  offset_q;                           // its first lane.
  xdata_t shifted;                            // field moved to bit 0.

  //////////////////////////////////////////////////
  // tag pipe, in step with the ram read
  //////////////////////////////////////////////////

  always_ff @(posedge i_clk) begin
    if (!i_rst_n) begin
      valid_q <= 1'b0;
    end else begin
      valid_q <= i_tag.valid;
    end
  end

  always_ff @(posedge i_clk) begin
    memop_q  <= i_tag.memop;                  // payload, follows valid.
    offset_q <= i_tag.offset;
  end

  assign shifted = i_raw >> {offset_q, 3'b000};

  always_comb begin
    case (memop_q)
      MEMOP_LB:  o_rdata = {{56{shifted[7]}}, shifted[7:0]};    // sign copy.
      MEMOP_LBU: o_rdata = {56'd0, shifted[7:0]};               // zero fill.
      MEMOP_LH:  o_rdata = {{48{shifted[15]}}, shifted[15:0]};
      MEMOP_LHU: o_rdata = {48'd0, shifted[15:0]};
      MEMOP_LW:  o_rdata = {{32{shifted[31]}}, shifted[31:0]};
      MEMOP_LWU: o_rdata = {32'd0, shifted[31:0]};
      default:   o_rdata = shifted;           // doubleword passes.
    endcase
  end

  assign o_rvalid = valid_q;

endmodule

//--- test/dmem_chk.sv
// load and fault checks

module dmem_chk
  import dmem_pkg::*;
(
  input logic       i_clk,
  input logic       i_rst_n,
  input logic       i_tag_valid,              // accepted load in the request cycle.
  input logic       i_rvalid,
  input logic       i_clr,                    // fault clear strobe.
  input logic       i_fault,
  input addr_t      i_fault_addr,
  input fault_cnt_t i_cnt
);

  int n_fail = 0;                             // failed assertions so far.

  // a response needs a load one cycle earlier.
  a_rvalid_tag: assert property (@(posedge i_clk) disable iff (!i_rst_n)
    i_rvalid |-> $past(i_tag_valid))
    else begin $error("rvalid without a load tag one cycle earlier"); n_fail++; end

  a_cnt_up: assert property (@(posedge i_clk)
    (i_rst_n && !i_clr) |=> (i_cnt >= $past(i_cnt)))  // only clear or reset lower it.
    else begin $error("fault count went down without clear or reset"); n_fail++; end

  a_rst_zero: assert property (@(posedge i_clk)
    !i_rst_n |=> (!i_fault && i_cnt == '0 && i_fault_addr == '0))
    else begin $error("fault outputs not zero in reset"); n_fail++; end

endmodule

// seen from the top, where tag, rvalid and fault outputs meet.
bind dmem_top dmem_chk u_chk (
  .i_clk        (i_clk),
  .i_rst_n      (i_rst_n),
  .i_tag_valid  (tag.valid),
  .i_rvalid     (o_rvalid),
  .i_clr        (i_fault_clr),
  .i_fault      (o_fault),
  .i_fault_addr (o_fault_addr),
  .i_cnt        (o_fault_cnt)
);

//--- test/dmem_tb.sv
// data memory testbench

module dmem_tb;
  import dmem_pkg::*;

  localparam int DEPTH      = 512;            // ram words.
  localparam int MEM_BYTES  = DEPTH * 8;      // model wraps here like the ram.
  localparam int N_RAND     = 400;            // random legal requests.
  localparam int N_SAT      = 300;            // faults for saturation.
  localparam int N_DIRECTED = 300;            // directed requests, idle and reset cycles.
  localparam int N_OPS      = N_RAND + N_SAT + N_DIRECTED;
  localparam memop_t OP_BAD = 3'd7;           // illegal code.

  logic       i_clk, i_rst_n, i_req, i_wr, i_fault_clr;
  memop_t     i_memop;
  addr_t      i_addr;
  xdata_t     i_wdata;
  logic       o_rvalid, o_fault;
  xdata_t     o_rdata;
  addr_t      o_fault_addr;
  fault_cnt_t o_fault_cnt;

  logic [7:0] mem_m [MEM_BYTES];              // byte model.
  bit         kn_w [DEPTH];                   // word written at least once.
  xdata_t     exp_q [$];                      // expected load data.
  bit         known_q [$];                    // data worth comparing.
  logic       flt_m = 1'b0;                   // fault flag model.
  addr_t      faddr_m = '0;
  fault_cnt_t fcnt_m = '0;
  int         n_val = 0;                      // wrong values.
  int         n_oth = 0;                      // missing or extra responses.

  dmem_top #(.DEPTH_WORDS(DEPTH)) UUT (.*);

  always #50 i_clk = ~i_clk;

  //////////////////////////////////////////////////
  // reference model
  //////////////////////////////////////////////////

  function automatic int acc_bytes(memop_t op);
    return 1 << op[2:1];                      // 1, 2, 4 or 8.
  endfunction

  function automatic bit is_legal(memop_t op, addr_t a);
    return (op != OP_BAD) && (a % acc_bytes(op) == 0);
  endfunction

  function automatic xdata_t ref_load(memop_t op, addr_t a);
    int     n;
    xdata_t v;
    n = acc_bytes(op);
    v = '0;
    for (int i = 0; i < n; i++) begin
      v[8*i +: 8] = mem_m[int'((a + i) % MEM_BYTES)]; // little endian.
    end
    if (!op[0] && n < 8 && v[8*n-1]) begin
      v = v | ~((64'd1 << (8 * n)) - 64'd1);  // even codes are signed.
    end
    return v;
  endfunction

  function automatic void model_store(memop_t op, addr_t a, xdata_t d);
    for (int i = 0; i < acc_bytes(op); i++) begin
      mem_m[int'((a + i) % MEM_BYTES)] = d[8*i +: 8];
    end
    kn_w[int'((a >> 3) % DEPTH)] = 1'b1;
  endfunction

  //////////////////////////////////////////////////
  // compare the outputs and then update the model
  //////////////////////////////////////////////////

  always @(posedge i_clk) begin : compare
    xdata_t exp_d;
    bit     exp_k;
    if (i_rst_n) begin
      if (exp_q.size() == 0) begin
        assert (!o_rvalid) else begin
          n_oth++;
          $display("ERROR: load response without a request at time %0t", $time);
        end
      end else begin
        exp_d = exp_q.pop_front();
        exp_k = known_q.pop_front();
        assert (o_rvalid) else begin
          n_oth++;
          $display("ERROR: no load response one cycle after the load at time %0t", $time);
        end
        if (o_rvalid && exp_k) begin
          assert (o_rdata === exp_d) else begin
            n_val++;
            $display("[FAIL] %0t o_rdata expected %h actual %h", $time, exp_d, o_rdata);
          end
        end
      end
      assert (o_fault === flt_m) else begin
        n_val++;
        $display("[FAIL] %0t o_fault expected %b actual %b", $time, flt_m, o_fault);
      end
      assert (o_fault_addr === faddr_m) else begin
        n_val++;
        $display("[FAIL] %0t o_fault_addr expected %h actual %h", $time, faddr_m, o_fault_addr);
      end
      assert (o_fault_cnt === fcnt_m) else begin
        n_val++;
        $display("[FAIL] %0t o_fault_cnt expected %0d actual %0d", $time, fcnt_m, o_fault_cnt);
      end
    end
    if (!i_rst_n || i_fault_clr) begin
      flt_m   = 1'b0;                         // clear beats a fault.
      faddr_m = '0;
      fcnt_m  = '0;
    end else if (i_req && !is_legal(i_memop, i_addr)) begin
      if (!flt_m) faddr_m = i_addr;           // first one only.
      flt_m = 1'b1;
      if (fcnt_m != 8'hff) fcnt_m = fcnt_m + 8'd1;
    end
    if (i_req && is_legal(i_memop, i_addr)) begin
      if (i_wr) begin
        model_store(i_memop, i_addr, i_wdata);
      end else if (i_rst_n) begin
        exp_q.push_back(ref_load(i_memop, i_addr));
        known_q.push_back(kn_w[int'((i_addr >> 3) % DEPTH)]);
      end
    end
  end

  //////////////////////////////////////////////////
  // stimulus driven on the falling edge
  //////////////////////////////////////////////////

  task automatic issue(input bit wr, input memop_t op, input addr_t a, input xdata_t d);
    @(negedge i_clk);
    i_req       = 1'b1;
    i_wr        = wr;
    i_memop     = op;
    i_addr      = a;
    i_wdata     = d;
    i_fault_clr = 1'b0;
  endtask

  task automatic idle_cycles(input int n);
    repeat (n) begin
      @(negedge i_clk);
      i_req       = 1'b0;
      i_fault_clr = 1'b0;
    end
  endtask

  task automatic clear_faults(input bit with_fault);
    @(negedge i_clk);
    i_fault_clr = 1'b1;
    i_req       = with_fault;                 // fault in the same cycle.
    i_wr        = 1'b0;
    i_memop     = OP_BAD;
    i_addr      = 64'h3f8;
  endtask

  initial begin : stimulus
    xdata_t pat [4];
    memop_t op;
    addr_t  a;
    bit     prev_wr;
    int     wd;
    int     errors;
    i_clk = 1'b0;
    i_rst_n = 1'b0;
    i_req = 1'b0;
    i_wr = 1'b0;
    i_memop = MEMOP_LD;
    i_addr = '0;
    i_wdata = '0;
    i_fault_clr = 1'b0;
    void'($urandom(32'h280ad1f2));
    pat = '{64'h8091_a2b3_c4d5_e6f7, 64'h0f1e_2d3c_4b5a_6978,
            64'hff00_7f80_0180_fe01, 64'h7fff_8000_ffff_0001};
    repeat (8) @(negedge i_clk);
    i_rst_n = 1'b1;
    issue(1'b0, MEMOP_LD, 64'h40, '0);        // straight out of reset.
    idle_cycles(2);
    // every legal code at every aligned offset
    for (int w = 0; w < 4; w++) issue(1'b1, MEMOP_LD, addr_t'(w * 8), pat[w]);
    for (int w = 0; w < 4; w++) begin
      for (int c = 0; c < 7; c++) begin
        for (int off = 0; off < 8; off++) begin
          if (is_legal(memop_t'(c), addr_t'(w * 8 + off)))
            issue(1'b0, memop_t'(c), addr_t'(w * 8 + off), '0);
        end
      end
    end
    // narrow stores each read back as a whole word
    issue(1'b1, MEMOP_LD, 64'h100, 64'h0123_4567_89ab_cdef);
    for (int c = 0; c < 6; c += 2) begin
      for (int off = 0; off < 8; off += acc_bytes(memop_t'(c))) begin
        issue(1'b1, memop_t'(c), 64'h100 + off, {$urandom(), $urandom()});
        issue(1'b0, MEMOP_LD, 64'h100, '0);
      end
    end
    // random traffic over eight words with wrapping high address bits
    for (int w = 0; w < 8; w++) issue(1'b1, MEMOP_LD, 64'h200 + w * 8, {$urandom(), $urandom()});
    prev_wr = 1'b0;
    wd = 0;
    for (int i = 0; i < N_RAND; i++) begin
      op = memop_t'($urandom_range(6));
      if (!(prev_wr && $urandom_range(1) == 1)) begin
        wd = $urandom_range(7);               // new word unless rereading a store.
      end
      a = {$urandom(), 20'($urandom()), 12'(12'h200 + wd * 8 + $urandom_range(7))};
      a = a & ~addr_t'(acc_bytes(op) - 1);    // align to the size.
      prev_wr = ($urandom_range(1) == 1);
      issue(prev_wr, op, a, {$urandom(), $urandom()});
    end
    idle_cycles(2);
    // rejected requests leave memory alone
    issue(1'b0, MEMOP_LH, 64'h101, '0);       // first fault address.
    issue(1'b1, MEMOP_LW, 64'h102, '1);
    issue(1'b1, MEMOP_LD, 64'h104, '1);
    issue(1'b1, OP_BAD, 64'h100, '1);
    issue(1'b0, MEMOP_LD, 64'h100, '0);
    clear_faults(1'b0);
    for (int i = 0; i < N_SAT; i++) issue(1'b1, OP_BAD, 64'h200 + i % 64, '1);
    for (int w = 0; w < 8; w++) issue(1'b0, MEMOP_LD, 64'h200 + w * 8, '0);
    clear_faults(1'b1);
    issue(1'b0, MEMOP_LW, 64'h6, '0);         // captured again after the clear.
    idle_cycles(3);
    errors = n_val + n_oth + UUT.u_chk.n_fail;
    $display("summary: %0d value errors, %0d response errors, %0d assertion errors",
             n_val, n_oth, UUT.u_chk.n_fail);
    if (errors == 0) begin
      $display("Test OK");
    end else begin
      $display("Test FAILED");
    end
    $finish;
  end

  initial begin : watchdog
    #((N_OPS + 20) * 100);
    $display("ERROR: simulation did not finish in time");
    $display("Test FAILED");
    $finish;
  end

endmodule

//--- verilog/dmem_fault_regs.sv
// access fault status registers

module dmem_fault_regs
  import dmem_pkg::*;
(
  input  logic       i_clk,
  input  logic       i_rst_n,
  input  fault_evt_t i_evt,                   // rejected request this cycle.
  input  logic       i_clr,                   // clear strobe, beats a fault.
  output logic       o_fault,
  output addr_t      o_fault_addr,
  output fault_cnt_t o_fault_cnt
);

  logic       flag_q;                         // sticky fault flag.
  addr_t      addr_q;                         // first fault address.
  fault_cnt_t cnt_q;                          // saturating count.

  //////////////////////////////////////////////////
  // status update
  //////////////////////////////////////////////////

  always_ff @(posedge i_clk) begin
    if (!i_rst_n) begin
      flag_q <= 1'b0;
      addr_q <= '0;
      cnt_q  <= '0;
    end else if (i_clr) begin
      flag_q <= 1'b0;                         // clear wins over a fault.
      addr_q <= '0;
      cnt_q  <= '0;
    end else if (i_evt.valid) begin
      flag_q <= 1'b1;
      if (!flag_q) begin
        addr_q <= i_evt.addr;                 // keep the first one only.
      end
      if (cnt_q != FAULT_CNT_MAX) begin
        cnt_q <= cnt_q + 1'b1;                // stops at 255.
      end
    end
  end

  assign o_fault      = flag_q;
  assign o_fault_addr = addr_q;
  assign o_fault_cnt  = cnt_q;

endmodule

//--- verilog/dmem_ram.sv
// byte enabled word ram

module dmem_ram
  import dmem_pkg::*;
#(
  parameter int DEPTH_WORDS = 512             // power of two, up to 65536.
) (
  input  logic     i_clk,
  input  ram_cmd_t i_cmd,
  output xdata_t   o_rdata                    // registered read word.
);

  localparam int AW = $clog2(DEPTH_WORDS);    // index bits used.

  xdata_t          mem [DEPTH_WORDS];         // word array, no reset.
  logic [AW-1:0]   idx;                       // wrapped word index.

  assign idx = i_cmd.index[AW-1:0];           // high bits dropped, memory wraps.

  //////////////////////////////////////////////////
  // per-byte write, registered read
  //////////////////////////////////////////////////

  always_ff @(posedge i_clk) begin
    for (int b = 0; b < 8; b++) begin
      if (i_cmd.we && i_cmd.mask[b]) begin
        mem[idx][b*8 +: 8] <= i_cmd.wdata[b*8 +: 8]; // masked lane only.
      end
    end
  end

  always_ff @(posedge i_clk) begin
    if (i_cmd.en) begin
      o_rdata <= mem[idx];                    // old word on a store, unused.
    end
  end

endmodule

//--- verilog/dmem_top.sv
// data memory top level

module dmem_top
  import dmem_pkg::*;
#(
  parameter int DEPTH_WORDS = 512             // ram depth in 64-bit words.
) (
  input  logic       i_clk,
  input  logic       i_rst_n,
  // request
  input  logic       i_req,                   // one-cycle request strobe.
  input  logic       i_wr,                    // store when set.
  input  memop_t     i_memop,
  input  addr_t      i_addr,
  input  xdata_t     i_wdata,
  // fault status
  input  logic       i_fault_clr,             // clears the fault block.
  // load response
  output logic       o_rvalid,
  output xdata_t     o_rdata,
  output logic       o_fault,
  output addr_t      o_fault_addr,
  output fault_cnt_t o_fault_cnt
);

  ram_cmd_t   cmd;                            // decode to ram.
  load_tag_t  tag;                            // decode to load extend.
  fault_evt_t evt;                            // decode to fault block.
  xdata_t     raw;                            // ram word, one cycle later.

  lsu_access_decode u_decode (
    .i_req   (i_req),
    .i_wr    (i_wr),
    .i_memop (i_memop),
    .i_addr  (i_addr),
    .i_wdata (i_wdata),
    .o_cmd   (cmd),
    .o_tag   (tag),
    .o_fault (evt)
  );

  dmem_ram #(.DEPTH_WORDS(DEPTH_WORDS)) u_ram (
    .i_clk   (i_clk),
    .i_cmd   (cmd),
    .o_rdata (raw)
  );

  lsu_load_extend u_extend (
    .i_clk    (i_clk),
    .i_rst_n  (i_rst_n),
    .i_tag    (tag),
    .i_raw    (raw),
    .o_rvalid (o_rvalid),
    .o_rdata  (o_rdata)
  );

  dmem_fault_regs u_fault (
    .i_clk        (i_clk),
    .i_rst_n      (i_rst_n),
    .i_evt        (evt),
    .i_clr        (i_fault_clr),
    .o_fault      (o_fault),
    .o_fault_addr (o_fault_addr),
    .o_fault_cnt  (o_fault_cnt)
  );

endmodule
